//--- logic/trap_pkg.sv
// Shared constants and types for an RV32 machine-mode trap block; only M-mode, no delegation.
package trap_pkg;

    // Data and CSR width.
    localparam int xlen = 32;
    // Interrupt causes covered by mie and mip.
    localparam int irq_lines = 32;
    // Width of the cause field in mcause.
    localparam int cause_w = 5;
    // Width of a CSR address.
    localparam int csr_addr_w = 12;

    typedef logic [csr_addr_w-1:0] addr_t;
    typedef logic [xlen-1:0] word_t;
    typedef logic [cause_w-1:0] cause_t;
    // Halfword aligned program counter with bit 0 implied zero.
    typedef logic [xlen-1:1] pc_t;
    // Word aligned trap vector for direct mode only.
    typedef logic [xlen-1:2] tvec_t;

    // Machine CSR addresses.
    localparam addr_t csr_mstatus = 12'h300;
    localparam addr_t csr_misa = 12'h301;
    localparam addr_t csr_medeleg = 12'h302;
    localparam addr_t csr_mideleg = 12'h303;
    localparam addr_t csr_mie = 12'h304;
    localparam addr_t csr_mtvec = 12'h305;
    localparam addr_t csr_mstatush = 12'h310;
    localparam addr_t csr_mscratch = 12'h340;
    localparam addr_t csr_mepc = 12'h341;
    localparam addr_t csr_mcause = 12'h342;
    localparam addr_t csr_mtval = 12'h343;
    localparam addr_t csr_mip = 12'h344;
    localparam addr_t csr_mvendorid = 12'hf11;
    localparam addr_t csr_marchid = 12'hf12;
    localparam addr_t csr_mimpid = 12'hf13;
    localparam addr_t csr_mhartid = 12'hf14;
    localparam addr_t csr_mconfigptr = 12'hf15;

    // Field positions.
    localparam int mstatus_mie_bit = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mcause_int_bit = 31;
    localparam int timer_irq_num = 7;
    localparam int ext_irq_lo = 16;

    // MXL=1 (32-bit) with C, I and M present.
    localparam word_t misa_value = 32'h4000_1104;
    localparam word_t arch_id = 32'd37;
    // Major 1, minor 4, patch 0.
    localparam word_t impl_id = 32'h0000_0140;
    localparam word_t hart_id = 32'h0000_0000;

    // Edges that mstatus.MIE must hold before interrupts are taken.
    localparam int mie_settle_depth = 2;

endpackage

//--- logic/irq_arbiter.sv
// Interrupt latch and trap dispatch; irq lines are assumed synchronous to clk, depth >= 2.
module irq_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic [trap_pkg::xlen-1:trap_pkg::ext_irq_lo] irq,
    input  logic timer_irq,
    input  trap_pkg::word_t mie_reg,
    input  logic mstatus_mie,
    input  logic insn_valid,
    input  logic trap,
    input  trap_pkg::cause_t trap_cause,
    output trap_pkg::word_t irq_ip,
    output logic ex_irq,
    output logic ex_trap,
    output trap_pkg::cause_t ex_cause,
    output logic take_exception
);

    // Raw pending word before the register.
    trap_pkg::word_t irq_raw;
    // Pending and enabled.
    trap_pkg::word_t irq_mask;
    // Lowest numbered enabled pending line.
    trap_pkg::cause_t irq_cause;
    // History of mstatus.MIE, newest in bit 0.
    logic [trap_pkg::mie_settle_depth-1:0] mie_hist;
    // Interrupt enable has been stable long enough.
    logic irq_en;

    // External lines in the upper half, timer at its standard slot.
    always_comb begin
        irq_raw = '0;
        irq_raw[trap_pkg::xlen-1:trap_pkg::ext_irq_lo] = irq;
        irq_raw[trap_pkg::timer_irq_num] = timer_irq;
    end

    // One register stage on the pending lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_ip <= '0;
        end else begin
            irq_ip <= irq_raw;
        end
    end

    assign irq_mask = irq_ip & mie_reg;

    // Scan downward so the lowest set bit wins.
    always_comb begin
        irq_cause = '0;
        for (int i = trap_pkg::irq_lines - 1; i >= 0; i--) begin
            if (irq_mask[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    // Shift in MIE every cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= {mie_hist[trap_pkg::mie_settle_depth-2:0], mstatus_mie};
        end
    end

    // A fresh MIE write must age through the whole history first.
    assign irq_en = (&mie_hist) && mstatus_mie;

    // Interrupts only attach to a retiring instruction.
    // Cause 0 is never a pending line, so zero means none.
    assign ex_irq = (irq_cause != '0) && irq_en && insn_valid;

    // A synchronous trap yields to an interrupt in the same cycle.
    assign ex_trap = !ex_irq && trap;

    assign ex_cause = ex_irq ? irq_cause : trap_cause;

    // Redirect request for the pipeline.
    assign take_exception = ex_irq || ex_trap;

endmodule

//--- logic/csr_regfile.sv
// Machine CSR file; direct-mode mtvec only, misa is fixed, delegation and mtval read zero.
module csr_regfile (
    input  logic clk,
    input  logic rst,
    input  trap_pkg::addr_t csr_addr,
    input  logic csr_we,
    input  trap_pkg::word_t csr_wdata,
    input  logic ex_irq,
    input  logic ex_trap,
    input  trap_pkg::cause_t ex_cause,
    input  trap_pkg::pc_t ex_pc,
    input  logic mret,
    input  trap_pkg::word_t irq_ip,
    output trap_pkg::word_t csr_rdata,
    output logic csr_exists,
    output logic csr_rdonly,
    output trap_pkg::word_t mie_reg,
    output logic mstatus_mie,
    output trap_pkg::tvec_t tvec,
    output trap_pkg::pc_t ret_epc
);

    // Previous interrupt enable.
    logic mstatus_mpie;
    // Trap vector base, word aligned.
    trap_pkg::tvec_t mtvec;
    trap_pkg::word_t mscratch;
    // Return address without bit 0.
    trap_pkg::pc_t mepc;
    // mcause split into flag and code.
    logic mcause_int;
    trap_pkg::cause_t mcause_no;

    // Assembled read views.
    trap_pkg::word_t mstatus_word;
    trap_pkg::word_t mcause_word;
    trap_pkg::word_t mip_word;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[trap_pkg::mstatus_mie_bit] = mstatus_mie;
        mstatus_word[trap_pkg::mstatus_mpie_bit] = mstatus_mpie;
    end

    always_comb begin
        mcause_word = '0;
        mcause_word[trap_pkg::cause_w-1:0] = mcause_no;
        mcause_word[trap_pkg::mcause_int_bit] = mcause_int;
    end

    // Pending view shows enabled lines only.
    assign mip_word = irq_ip & mie_reg;

    // Read decode.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdata = '0;
        case (csr_addr)
            trap_pkg::csr_mstatus: csr_rdata = mstatus_word;
            trap_pkg::csr_misa: csr_rdata = trap_pkg::misa_value;
            trap_pkg::csr_mie: csr_rdata = mie_reg;
            trap_pkg::csr_mtvec: csr_rdata = {mtvec, 2'b00};
            trap_pkg::csr_mscratch: csr_rdata = mscratch;
            trap_pkg::csr_mepc: csr_rdata = {mepc, 1'b0};
            trap_pkg::csr_mcause: csr_rdata = mcause_word;
            trap_pkg::csr_mip: csr_rdata = mip_word;
            trap_pkg::csr_marchid: csr_rdata = trap_pkg::arch_id;
            trap_pkg::csr_mimpid: csr_rdata = trap_pkg::impl_id;
            trap_pkg::csr_mhartid: csr_rdata = trap_pkg::hart_id;
            // Present but hardwired to zero.
            trap_pkg::csr_medeleg, trap_pkg::csr_mideleg,
            trap_pkg::csr_mstatush, trap_pkg::csr_mtval,
            trap_pkg::csr_mvendorid, trap_pkg::csr_mconfigptr: csr_rdata = '0;
            default: csr_exists = 1'b0;
        endcase
    end

    // Top two address bits set means read-only in the standard encoding.
    // This covers exactly the ID block at 0xf11 to 0xf15.
    assign csr_rdonly = csr_exists
        && (csr_addr[trap_pkg::csr_addr_w-1:trap_pkg::csr_addr_w-2] == 2'b11);

    // Priority is reset, trap entry, software write, then mret.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_reg <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause_int <= 1'b0;
            mcause_no <= '0;
        end else if (ex_irq || ex_trap) begin
            // Stack the enable and disable further interrupts.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mepc <= ex_pc;
            mcause_int <= ex_irq;
            mcause_no <= ex_cause;
        end else if (csr_we) begin
            case (csr_addr)
                trap_pkg::csr_mstatus: begin
                    mstatus_mie <= csr_wdata[trap_pkg::mstatus_mie_bit];
                    mstatus_mpie <= csr_wdata[trap_pkg::mstatus_mpie_bit];
                end
                trap_pkg::csr_mie: mie_reg <= csr_wdata;
                trap_pkg::csr_mtvec: mtvec <= csr_wdata[trap_pkg::xlen-1:2];
                trap_pkg::csr_mscratch: mscratch <= csr_wdata;
                trap_pkg::csr_mepc: mepc <= csr_wdata[trap_pkg::xlen-1:1];
                trap_pkg::csr_mcause: begin
                    mcause_int <= csr_wdata[trap_pkg::mcause_int_bit];
                    mcause_no <= csr_wdata[trap_pkg::cause_w-1:0];
                end
                // Other addresses ignore writes.
                default: begin
                end
            endcase
        end else if (mret) begin
            // Restore the stacked enable.
            mstatus_mie <= mstatus_mpie;
        end
    end

    // Vector and return address straight from storage.
    assign tvec = mtvec;
    assign ret_epc = mepc;

endmodule

//--- logic/trap_unit.sv
// Trap and CSR top; expects a single retiring instruction per cycle and no back-pressure.
module trap_unit (
    input  logic clk,
    input  logic rst,
    input  trap_pkg::addr_t csr_addr,
    input  logic csr_we,
    input  trap_pkg::word_t csr_wdata,
    input  logic insn_valid,
    input  logic trap,
    input  trap_pkg::cause_t trap_cause,
    input  trap_pkg::pc_t trap_pc,
    input  logic mret,
    input  logic [trap_pkg::xlen-1:trap_pkg::ext_irq_lo] irq,
    input  logic timer_irq,
    output trap_pkg::word_t csr_rdata,
    output logic csr_exists,
    output logic csr_rdonly,
    output logic take_exception,
    output trap_pkg::tvec_t tvec,
    output trap_pkg::pc_t ret_epc
);

    // Dispatch result toward the CSR file.
    logic ex_irq;
    logic ex_trap;
    trap_pkg::cause_t ex_cause;
    // Enable state back toward the arbiter.
    trap_pkg::word_t mie_reg;
    logic mstatus_mie;
    // Latched pending lines.
    trap_pkg::word_t irq_ip;

    irq_arbiter u_arbiter (
        .clk(clk),
        .rst(rst),
        .irq(irq),
        .timer_irq(timer_irq),
        .mie_reg(mie_reg),
        .mstatus_mie(mstatus_mie),
        .insn_valid(insn_valid),
        .trap(trap),
        .trap_cause(trap_cause),
        .irq_ip(irq_ip),
        .ex_irq(ex_irq),
        .ex_trap(ex_trap),
        .ex_cause(ex_cause),
        .take_exception(take_exception)
    );

    // Both interrupts and traps save the retiring PC.
    csr_regfile u_csrs (
        .clk(clk),
        .rst(rst),
        .csr_addr(csr_addr),
        .csr_we(csr_we),
        .csr_wdata(csr_wdata),
        .ex_irq(ex_irq),
        .ex_trap(ex_trap),
        .ex_cause(ex_cause),
        .ex_pc(trap_pc),
        .mret(mret),
        .irq_ip(irq_ip),
        .csr_rdata(csr_rdata),
        .csr_exists(csr_exists),
        .csr_rdonly(csr_rdonly),
        .mie_reg(mie_reg),
        .mstatus_mie(mstatus_mie),
        .tvec(tvec),
        .ret_epc(ret_epc)
    );

endmodule

//--- sim/trap_unit_chk.sv
// Trap entry and dispatch assertions bound into trap_unit; sampled on the rising clock.
module trap_unit_chk (
    input logic clk,
    input logic rst,
    input logic take_exception,
    input logic mstatus_mie,
    input logic ex_irq,
    input logic ex_trap
);

    // Entry stacks the enable and clears MIE at the same edge.
    entry_clears_mie: assert property (
        @(posedge clk) disable iff (rst) take_exception |=> !mstatus_mie
    ) else $error("mstatus.MIE still set one cycle after trap entry");

    // No redirect while the block is held in reset.
    no_take_in_reset: assert property (
        @(posedge clk) rst |-> !take_exception
    ) else $error("take_exception high during reset");

    // The arbiter gives a trap only when no interrupt is taken.
    one_dispatch: assert property (
        @(posedge clk) disable iff (rst) !(ex_irq && ex_trap)
    ) else $error("interrupt and trap dispatched together");

endmodule

bind trap_unit trap_unit_chk u_chk (
    .clk(clk),
    .rst(rst),
    .take_exception(take_exception),
    .mstatus_mie(mstatus_mie),
    .ex_irq(ex_irq),
    .ex_trap(ex_trap)
);

//--- sim/trap_unit_tb.sv
// Directed tests of the trap unit; assumes a one-edge irq latch and a two-edge MIE settle.
module trap_unit_tb;

    // Well above the thirty or so cycles the tests need.
    localparam int watchdog_cycles = 200;
    // mstatus with only MIE set.
    localparam trap_pkg::word_t mie_on = 32'h1 << trap_pkg::mstatus_mie_bit;

    logic clk;
    logic rst;
    trap_pkg::addr_t csr_addr;
    logic csr_we;
    trap_pkg::word_t csr_wdata;
    logic insn_valid;
    logic trap;
    trap_pkg::cause_t trap_cause;
    trap_pkg::pc_t trap_pc;
    logic mret;
    logic [trap_pkg::xlen-1:trap_pkg::ext_irq_lo] irq;
    logic timer_irq;
    trap_pkg::word_t csr_rdata;
    logic csr_exists;
    logic csr_rdonly;
    logic take_exception;
    trap_pkg::tvec_t tvec;
    trap_pkg::pc_t ret_epc;

    int errors;
    // PC of the latest trap entry.
    trap_pkg::pc_t last_pc;

    trap_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ends a hung run.
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: watchdog expired before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_word(input string name, trap_pkg::word_t exp, trap_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, trap_pkg::pc_t exp, trap_pkg::pc_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cause(input string name, trap_pkg::cause_t exp, trap_pkg::cause_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Just past the next rising edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic csr_write(input trap_pkg::addr_t addr, trap_pkg::word_t data);
        csr_addr = addr;
        csr_wdata = data;
        csr_we = 1'b1;
        step();
        csr_we = 1'b0;
    endtask

    // Read decode is combinational, so one unit is enough.
    task automatic read_csr(input trap_pkg::addr_t addr);
        csr_addr = addr;
        #1;
    endtask

    task automatic expect_read(input string name, trap_pkg::addr_t addr, trap_pkg::word_t exp);
        read_csr(addr);
        check_word(name, exp, csr_rdata);
    endtask

    task automatic test_csr_access();
        trap_pkg::word_t r;
        expect_read("reset_mstatus", trap_pkg::csr_mstatus, '0);
        r = $urandom;
        csr_write(trap_pkg::csr_mscratch, r);
        expect_read("csr_mscratch", trap_pkg::csr_mscratch, r);
        check_bit("csr_mscratch_exists", 1'b1, csr_exists);
        check_bit("csr_mscratch_rw", 1'b0, csr_rdonly);
        r = $urandom;
        csr_write(trap_pkg::csr_mtvec, r);
        expect_read("csr_mtvec", trap_pkg::csr_mtvec, r & ~32'h3);
        r = $urandom;
        csr_write(trap_pkg::csr_mepc, r);
        expect_read("csr_mepc", trap_pkg::csr_mepc, r & ~32'h1);
        // ID block is read-only.
        expect_read("csr_marchid", trap_pkg::csr_marchid, trap_pkg::arch_id);
        check_bit("csr_marchid_ro", 1'b1, csr_rdonly);
        expect_read("csr_mimpid", trap_pkg::csr_mimpid, trap_pkg::impl_id);
        check_bit("csr_mimpid_ro", 1'b1, csr_rdonly);
        expect_read("csr_mhartid", trap_pkg::csr_mhartid, trap_pkg::hart_id);
        check_bit("csr_mhartid_ro", 1'b1, csr_rdonly);
        expect_read("csr_misa", trap_pkg::csr_misa, trap_pkg::misa_value);
        read_csr(12'h7c0);
        check_bit("csr_unlisted", 1'b0, csr_exists);
    endtask

    task automatic test_trap_entry();
        trap_pkg::word_t vec;
        trap_pkg::cause_t cause;
        vec = $urandom & ~32'h3;
        cause = trap_pkg::cause_t'($urandom);
        last_pc = trap_pkg::pc_t'($urandom);
        csr_write(trap_pkg::csr_mtvec, vec);
        csr_write(trap_pkg::csr_mstatus, mie_on);
        trap = 1'b1;
        trap_cause = cause;
        trap_pc = last_pc;
        #1;
        check_bit("trap_take", 1'b1, take_exception);
        check_word("trap_tvec", vec, {tvec, 2'b00});
        step();
        trap = 1'b0;
        expect_read("trap_mepc", trap_pkg::csr_mepc, {last_pc, 1'b0});
        read_csr(trap_pkg::csr_mcause);
        check_cause("trap_mcause", cause, csr_rdata[trap_pkg::cause_w-1:0]);
        check_bit("trap_mcause_int", 1'b0, csr_rdata[trap_pkg::mcause_int_bit]);
        read_csr(trap_pkg::csr_mstatus);
        check_bit("trap_mie", 1'b0, csr_rdata[trap_pkg::mstatus_mie_bit]);
        check_bit("trap_mpie", 1'b1, csr_rdata[trap_pkg::mstatus_mpie_bit]);
    endtask

    // MPIE is 1 from the trap before.
    task automatic test_mret();
        check_pc("mret_epc", last_pc, ret_epc);
        mret = 1'b1;
        step();
        mret = 1'b0;
        read_csr(trap_pkg::csr_mstatus);
        check_bit("mret_mie", 1'b1, csr_rdata[trap_pkg::mstatus_mie_bit]);
    endtask

    task automatic test_irq_priority();
        last_pc = trap_pkg::pc_t'($urandom);
        // Timer plus lines 17 and 20.
        csr_write(trap_pkg::csr_mie, 32'h0012_0080);
        csr_write(trap_pkg::csr_mstatus, mie_on);
        step();
        step();
        irq[17] = 1'b1;
        irq[20] = 1'b1;
        timer_irq = 1'b1;
        insn_valid = 1'b1;
        trap_pc = last_pc;
        #1;
        check_bit("prio_before_latch", 1'b0, take_exception);
        step();
        #1;
        check_bit("prio_take", 1'b1, take_exception);
        step();
        irq = '0;
        timer_irq = 1'b0;
        insn_valid = 1'b0;
        // Interrupt flag with the timer cause.
        expect_read("prio_mcause", trap_pkg::csr_mcause, 32'h8000_0007);
        check_pc("prio_mepc", last_pc, ret_epc);
    endtask

    task automatic test_irq_gating();
        csr_write(trap_pkg::csr_mstatus, mie_on);
        step();
        step();
        irq[17] = 1'b1;
        step();
        #1;
        check_bit("gate_valid", 1'b0, take_exception);
        expect_read("gate_mip", trap_pkg::csr_mip, 32'h1 << 17);
        // Line 18 is pending but not enabled.
        irq[17] = 1'b0;
        irq[18] = 1'b1;
        step();
        insn_valid = 1'b1;
        #1;
        check_bit("gate_mask", 1'b0, take_exception);
        // Only line 18 is latched and mie lacks it.
        expect_read("gate_mip_masked", trap_pkg::csr_mip, '0);
        irq[18] = 1'b0;
        irq[17] = 1'b1;
        csr_write(trap_pkg::csr_mstatus, '0);
        step();
        step();
        // Fresh MIE has not aged yet.
        csr_write(trap_pkg::csr_mstatus, mie_on);
        #1;
        check_bit("gate_settle", 1'b0, take_exception);
        insn_valid = 1'b0;
        step();
        step();
        // Interrupt and trap together.
        insn_valid = 1'b1;
        trap = 1'b1;
        trap_cause = trap_pkg::cause_t'($urandom);
        #1;
        check_bit("gate_win_take", 1'b1, take_exception);
        step();
        insn_valid = 1'b0;
        trap = 1'b0;
        irq = '0;
        expect_read("gate_win_mcause", trap_pkg::csr_mcause, 32'h8000_0011);
    endtask

    initial begin
        void'($urandom(32'hfa66));
        errors = 0;
        rst = 1'b1;
        csr_addr = '0;
        csr_we = 1'b0;
        csr_wdata = '0;
        insn_valid = 1'b0;
        trap = 1'b0;
        trap_cause = '0;
        trap_pc = '0;
        mret = 1'b0;
        irq = '0;
        timer_irq = 1'b0;
        last_pc = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_csr_access();
        test_trap_entry();
        test_mret();
        test_irq_priority();
        test_irq_gating();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/trap_pkg.sv
logic/irq_arbiter.sv
logic/csr_regfile.sv
logic/trap_unit.sv
sim/trap_unit_chk.sv
sim/trap_unit_tb.sv

//--- Makefile
# Verilator build and run of the trap unit testbench.

obj_dir/Vtrap_unit_tb: verilog.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)
	verilator --binary --assert --top-module trap_unit_tb -f verilog.f

run: obj_dir/Vtrap_unit_tb
	./obj_dir/Vtrap_unit_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
